/* cpuTop.f */
+incdir+hw
hw/cpuPkg.sv
hw/pipeBuses.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardUnit.sv
hw/forwardUnit.sv
hw/executeStage.sv
hw/memStage.sv
hw/cpuTop.sv
bench/clkGen.sv
bench/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cpuTop testbench with Verilator and run it
# the run counts as passed only if the pass message shows up in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f cpuTop.f -o cpuSim \
	&& ./obj_dir/cpuSim | tee /dev/stderr | grep -qF 'All tests passed!' \
	&& echo "simulation: PASS" \
	|| { echo "simulation: FAIL"; exit 1; }

/* bench/cpuTb.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module cpuTb
	import cpuPkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int PROG_MAX = 64;
	// program lengths, the watchdog budget is built from them
	localparam int LEN_CHAIN = 10;
	localparam int LEN_IMM = 8;
	localparam int LEN_MEM = 13;
	localparam int LEN_BRANCH = 18;
	localparam int RAND_LEN = 20;
	localparam int RAND_TESTS = 40;
	localparam int BUDGET_CYCLES = (LEN_CHAIN * 3 + 40) + (LEN_IMM * 3 + 40)
		+ (LEN_MEM * 3 + 40) + (LEN_BRANCH * 3 + 40) + RAND_TESTS * (RAND_LEN * 3 + 40);
	// reference model gives up on runaway loops
	localparam int STEP_MAX = 1000;

	typedef struct packed
	{
		logic [`REG_W-1:0] regId;
		logic [`DATA_W-1:0] value;
	} wbPair;

	logic CLK;
	logic RST;
	logic rstReq;
	logic [`DATA_W-1:0] imemData;
	logic [`DATA_W-1:0] imemAddr;
	logic wbValid;
	logic [`REG_W-1:0] wbReg;
	logic [`DATA_W-1:0] wbData;

	// program seen by the core, and the next one being built
	logic [`DATA_W-1:0] prog [PROG_MAX];
	int progLen;
	logic [`DATA_W-1:0] stage [PROG_MAX];
	int stageLen;
	wbPair expQ [$];
	wbPair wantPair;
	bit checking;
	int testErrors;
	int passCount;
	int failCount;
	int seed;

	clkGen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) clk0 (.rstReq(rstReq), .CLK(CLK), .RST(RST));

	cpuTop dut0 (.CLK(CLK), .RST(RST), .imemData(imemData), .imemAddr(imemAddr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

	// instruction memory, nop past the end of the program
	always_comb
	begin
		if (int'(imemAddr) < progLen)
			imemData = prog[imemAddr[$clog2(PROG_MAX)-1:0]];
		else
			imemData = `NOP_WORD;
	end

	// ---------------------------------------------------------------------------
	// instruction words
	// ---------------------------------------------------------------------------
	function automatic logic [`DATA_W-1:0] rrrWord(input logic [`REG_W-1:0] rx,
		input logic [`REG_W-1:0] ry, input logic [`REG_W-1:0] rz, input logic [`FN_W-1:0] fn);
		instrWord w;
		w.regView.op = `OP_RRR;
		w.regView.rx = rx;
		w.regView.ry = ry;
		w.regView.rz = rz;
		w.regView.fn = fn;
		return w;
	endfunction

	function automatic logic [`DATA_W-1:0] immWord(input logic [`OP_W-1:0] op,
		input logic [`REG_W-1:0] rx, input logic [7:0] imm8);
		instrWord w;
		w.immView.op = op;
		w.immView.rx = rx;
		w.immView.imm8 = imm8;
		return w;
	endfunction

	function automatic logic [`DATA_W-1:0] memWord(input logic [`OP_W-1:0] op,
		input logic [`REG_W-1:0] rx, input logic [`REG_W-1:0] ry, input logic [4:0] imm5);
		instrWord w;
		w.memView.op = op;
		w.memView.rx = rx;
		w.memView.ry = ry;
		w.memView.imm5 = imm5;
		return w;
	endfunction

	task automatic addInstr(input logic [`DATA_W-1:0] w);
		stage[stageLen] = w;
		stageLen++;
	endtask

	// ---------------------------------------------------------------------------
	// reference model, one instruction per step, no delay slot
	// ---------------------------------------------------------------------------
	function automatic void refRun();
		logic [`DATA_W-1:0] r [`NUM_REGS];
		logic [`DATA_W-1:0] mem [`DMEM_WORDS];
		instrWord w;
		logic [`DATA_W-1:0] sext8;
		logic [`DATA_W-1:0] sext5;
		logic [`DATA_W-1:0] ea;
		wbPair p;
		int pc;
		int steps;
		for (int i = 0; i < `NUM_REGS; i++)
			r[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			mem[i] = '0;
		pc = 0;
		steps = 0;
		while (pc >= 0 && pc < progLen && steps < STEP_MAX)
		begin
			w = prog[pc];
			sext8 = {{(`DATA_W-8){w.immView.imm8[7]}}, w.immView.imm8};
			sext5 = {{(`DATA_W-5){w.memView.imm5[4]}}, w.memView.imm5};
			// effective address, only low bits reach the memory
			ea = r[w.memView.rx] + sext5;
			pc++;
			steps++;
			p.regId = w.immView.rx;
			case (w.regView.op)
				`OP_ADDIU:
				begin
					r[w.immView.rx] = r[w.immView.rx] + sext8;
					p.value = r[w.immView.rx];
					expQ.push_back(p);
				end
				`OP_LI:
				begin
					r[w.immView.rx] = {8'h00, w.immView.imm8};
					p.value = r[w.immView.rx];
					expQ.push_back(p);
				end
				`OP_RRR:
				begin
					case (w.regView.fn)
						`FN_AND: p.value = r[w.regView.rx] & r[w.regView.ry];
						`FN_ADDU: p.value = r[w.regView.rx] + r[w.regView.ry];
						`FN_OR: p.value = r[w.regView.rx] | r[w.regView.ry];
						default: p.value = r[w.regView.rx] - r[w.regView.ry];
					endcase
					r[w.regView.rz] = p.value;
					p.regId = w.regView.rz;
					expQ.push_back(p);
				end
				`OP_LW:
				begin
					r[w.memView.ry] = mem[ea[`DMEM_AW-1:0]];
					p.regId = w.memView.ry;
					p.value = r[w.memView.ry];
					expQ.push_back(p);
				end
				`OP_SW:
					mem[ea[`DMEM_AW-1:0]] = r[w.memView.ry];
				`OP_BEQZ:
				begin
					// pc already points past the branch
					if (r[w.immView.rx] == '0)
						pc = pc + $signed(sext8);
				end
				`OP_JR:
					pc = int'(r[w.immView.rx]);
				default:
					pc = pc;
			endcase
		end
	endfunction

	// ---------------------------------------------------------------------------
	// programs
	// ---------------------------------------------------------------------------
	// every instruction reads the one before, all four function codes
	task automatic chainProgram();
		stageLen = 0;
		addInstr(immWord(`OP_LI, 3'd1, 8'h5A));
		addInstr(immWord(`OP_LI, 3'd2, 8'h0F));
		addInstr(rrrWord(3'd1, 3'd2, 3'd3, `FN_AND));
		addInstr(rrrWord(3'd3, 3'd1, 3'd4, `FN_ADDU));
		addInstr(rrrWord(3'd4, 3'd2, 3'd5, `FN_OR));
		addInstr(rrrWord(3'd5, 3'd3, 3'd6, `FN_SUBU));
		addInstr(rrrWord(3'd6, 3'd1, 3'd7, `FN_SUBU));
		addInstr(rrrWord(3'd7, 3'd7, 3'd7, `FN_ADDU));
		addInstr(rrrWord(3'd7, 3'd6, 3'd0, `FN_OR));
		addInstr(rrrWord(3'd0, 3'd4, 3'd1, `FN_SUBU));
	endtask

	// immediates with bit 7 set, li zero extends, addiu sign extends
	task automatic immProgram();
		stageLen = 0;
		addInstr(immWord(`OP_LI, 3'd1, 8'h80));
		addInstr(immWord(`OP_ADDIU, 3'd1, 8'h80));
		addInstr(immWord(`OP_LI, 3'd2, 8'hFF));
		addInstr(immWord(`OP_ADDIU, 3'd2, 8'hFF));
		addInstr(immWord(`OP_ADDIU, 3'd3, 8'h85));
		addInstr(immWord(`OP_ADDIU, 3'd3, 8'h7F));
		addInstr(immWord(`OP_LI, 3'd4, 8'h7F));
		addInstr(immWord(`OP_ADDIU, 3'd4, 8'h90));
	endtask

	// stores before loads, each load used right away
	task automatic memProgram();
		stageLen = 0;
		addInstr(immWord(`OP_LI, 3'd1, 8'h20));
		addInstr(immWord(`OP_LI, 3'd2, 8'hAB));
		addInstr(memWord(`OP_SW, 3'd1, 3'd2, 5'd3));
		addInstr(memWord(`OP_LW, 3'd1, 3'd3, 5'd3));
		addInstr(rrrWord(3'd3, 3'd2, 3'd4, `FN_ADDU));
		addInstr(memWord(`OP_SW, 3'd1, 3'd4, 5'h1F));
		addInstr(memWord(`OP_LW, 3'd1, 3'd5, 5'h1F));
		addInstr(immWord(`OP_ADDIU, 3'd5, 8'h01));
		addInstr(memWord(`OP_SW, 3'd1, 3'd5, 5'd1));
		addInstr(memWord(`OP_LW, 3'd1, 3'd7, 5'd1));
		// loaded value goes straight out as store data
		addInstr(memWord(`OP_SW, 3'd1, 3'd7, 5'd2));
		addInstr(memWord(`OP_LW, 3'd1, 3'd0, 5'd2));
		addInstr(rrrWord(3'd0, 3'd0, 3'd2, `FN_OR));
	endtask

	// taken, not taken, jr, and a short countdown loop
	task automatic branchProgram();
		stageLen = 0;
		addInstr(immWord(`OP_LI, 3'd1, 8'h00));
		addInstr(immWord(`OP_BEQZ, 3'd1, 8'h02));
		addInstr(immWord(`OP_LI, 3'd2, 8'h11));
		addInstr(immWord(`OP_LI, 3'd3, 8'h22));
		addInstr(immWord(`OP_LI, 3'd4, 8'h05));
		addInstr(immWord(`OP_BEQZ, 3'd4, 8'h03));
		addInstr(immWord(`OP_LI, 3'd5, 8'h33));
		addInstr(immWord(`OP_LI, 3'd6, 8'd12));
		addInstr(immWord(`OP_JR, 3'd6, 8'h00));
		addInstr(immWord(`OP_LI, 3'd2, 8'h44));
		addInstr(immWord(`OP_LI, 3'd3, 8'h55));
		addInstr(immWord(`OP_LI, 3'd7, 8'h66));
		addInstr(immWord(`OP_ADDIU, 3'd6, 8'h01));
		addInstr(immWord(`OP_LI, 3'd1, 8'h03));
		addInstr(immWord(`OP_ADDIU, 3'd1, 8'hFF));
		addInstr(immWord(`OP_BEQZ, 3'd1, 8'h01));
		// r0 stays zero here, so this always jumps back
		addInstr(immWord(`OP_BEQZ, 3'd0, 8'hFD));
		addInstr(rrrWord(3'd4, 3'd5, 3'd7, `FN_ADDU));
	endtask

	// straight-line mix, rrr twice as likely
	task automatic randomProgram();
		logic [31:0] r;
		stageLen = 0;
		for (int i = 0; i < RAND_LEN; i++)
		begin
			r = $random(seed);
			case (r[1:0])
				2'd0: addInstr(immWord(`OP_LI, r[4:2], r[12:5]));
				2'd1: addInstr(immWord(`OP_ADDIU, r[4:2], r[12:5]));
				default: addInstr(rrrWord(r[4:2], r[7:5], r[10:8], r[12:11]));
			endcase
		end
	endtask

	// ---------------------------------------------------------------------------
	// one test: reset, swap program, wait for the expected write-backs
	// ---------------------------------------------------------------------------
	task automatic runTest(input string name);
		int waited;
		int writes;
		@(posedge CLK);
		rstReq <= 1'b1;
		@(posedge CLK);
		rstReq <= 1'b0;
		wait (RST == 1'b0);
		// core is held in reset while the program changes
		for (int i = 0; i < stageLen; i++)
			prog[i] = stage[i];
		progLen = stageLen;
		expQ.delete();
		refRun();
		writes = expQ.size();
		testErrors = 0;
		wait (RST == 1'b1);
		checking = 1'b1;
		waited = 0;
		while (expQ.size() != 0 && waited < progLen * 2 + 10)
		begin
			@(posedge CLK);
			waited++;
		end
		// quiet tail, late or extra writes still get caught
		repeat (20) @(posedge CLK);
		checking = 1'b0;
		if (expQ.size() != 0)
		begin
			$display("test %s: %0d expected write-backs never showed up", name, expQ.size());
			testErrors++;
		end
		if (testErrors == 0)
		begin
			passCount++;
			$display("test %s: PASS, %0d write-backs", name, writes);
		end
		else
		begin
			failCount++;
			$display("test %s: FAIL, %0d errors", name, testErrors);
		end
	endtask

	// compare on the falling edge, write-back outputs are settled there
	always @(negedge CLK)
	begin
		if (checking && wbValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("at %0d ns the core wrote r%0d = %h after all expected write-backs",
					$time, wbReg, wbData);
				testErrors++;
			end
			else
			begin
				wantPair = expQ.pop_front();
				if (wbReg !== wantPair.regId)
				begin
					$display("ERROR at %0d ns: wbReg is %0d, expected %0d",
						$time, wbReg, wantPair.regId);
					testErrors++;
				end
				if (wbData !== wantPair.value)
				begin
					$display("ERROR at %0d ns: wbData is %h, expected %h",
						$time, wbData, wantPair.value);
					testErrors++;
				end
			end
		end
	end

	initial
	begin
		seed = 64969;
		passCount = 0;
		failCount = 0;
		testErrors = 0;
		checking = 1'b0;
		progLen = 0;
		rstReq <= 1'b0;
		chainProgram();
		runTest("chain");
		immProgram();
		runTest("immediates");
		memProgram();
		runTest("load-use");
		branchProgram();
		runTest("branches");
		for (int t = 0; t < RAND_TESTS; t++)
		begin
			randomProgram();
			runTest($sformatf("random %0d", t));
		end
		$display("tests run: %0d, passed: %0d, failed: %0d",
			passCount + failCount, passCount, failCount);
		if (failCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog, budget summed over all programs
	initial
	begin
		#(BUDGET_CYCLES * CLK_PERIOD);
		$display("watchdog: run still going after %0d cycles, stopping", BUDGET_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

/* bench/clkGen.sv */
`timescale 1ns/10ps

// free-running clock and an active-low reset
module clkGen
#(
	parameter int PERIOD = 8,
	parameter int RST_CYCLES = 4
)
(
	input  logic rstReq,
	output logic CLK,
	output logic RST
);

	initial
	begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// power-up reset, then another one on each request
	initial
	begin
		RST <= 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		RST <= 1'b1;
		forever
		begin
			@(posedge CLK);
			if (rstReq)
			begin
				RST <= 1'b0;
				repeat (RST_CYCLES) @(posedge CLK);
				RST <= 1'b1;
			end
		end
	end

endmodule

/* hw/cpuTop.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module cpuTop
(
	input  logic CLK,
	input  logic RST,
	input  logic [`DATA_W-1:0] imemData,
	output logic [`DATA_W-1:0] imemAddr,
	output logic wbValid,
	output logic [`REG_W-1:0] wbReg,
	output logic [`DATA_W-1:0] wbData
);

	logic stall;
	logic redirect;
	logic [`DATA_W-1:0] target;
	logic [`DATA_W-1:0] ifInstr;
	logic [`DATA_W-1:0] ifPcPlus;
	logic [1:0] fwdA;
	logic [1:0] fwdB;

	// pipeline registers between stages
	idExBus idEx0 ();
	exMemBus exMem0 ();

	fetchStage fetch0 (.CLK(CLK), .RST(RST), .stall(stall), .redirect(redirect),
		.target(target), .imemAddr(imemAddr), .imemData(imemData), .ifInstr(ifInstr),
		.ifPcPlus(ifPcPlus));

	decodeStage decode0 (.CLK(CLK), .RST(RST), .ifInstr(ifInstr), .ifPcPlus(ifPcPlus),
		.stall(stall), .redirect(redirect), .wbValid(wbValid), .wbReg(wbReg),
		.wbData(wbData), .idEx(idEx0.issue));

	// load-use check against the instruction still in IF/ID
	hazardUnit hazard0 (.ifInstr(ifInstr), .idEx(idEx0.watch), .stall(stall));

	forwardUnit forward0 (.idEx(idEx0.watch), .exMem(exMem0.watch), .wbValid(wbValid),
		.wbReg(wbReg), .fwdA(fwdA), .fwdB(fwdB));

	executeStage execute0 (.CLK(CLK), .RST(RST), .idEx(idEx0.exec), .fwdA(fwdA),
		.fwdB(fwdB), .wbData(wbData), .exMem(exMem0.issue), .redirect(redirect),
		.target(target));

	// write-back triple leaves the core from here
	memStage mem0 (.CLK(CLK), .RST(RST), .exMem(exMem0.mem), .wbValid(wbValid),
		.wbReg(wbReg), .wbData(wbData));

endmodule

/* hw/memStage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module memStage
(
	input  logic CLK,
	input  logic RST,
	exMemBus.mem exMem,
	output logic wbValid,
	output logic [`REG_W-1:0] wbReg,
	output logic [`DATA_W-1:0] wbData
);

	logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] addr;
	logic [`DATA_W-1:0] loadData;
	logic wbIsLoad;
	logic [`DATA_W-1:0] wbAlu;
	logic [`DATA_W-1:0] wbLoad;

	// upper address bits ignored
	assign addr = exMem.aluResult[`DMEM_AW-1:0];
	assign loadData = dmem[addr];

	always_ff @(posedge CLK)
	begin
		if (exMem.memWrite)
			dmem[addr] <= exMem.storeData;
	end

	// MEM/WB flags
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			wbValid <= 1'b0;
			wbIsLoad <= 1'b0;
		end
		else
		begin
			wbValid <= exMem.regWrite;
			wbIsLoad <= exMem.memRead;
		end
	end

	always_ff @(posedge CLK)
	begin
		wbReg <= exMem.dest;
		wbAlu <= exMem.aluResult;
		wbLoad <= loadData;
	end

	// write-back mux
	assign wbData = wbIsLoad ? wbLoad : wbAlu;

	// decode never sets both
	rwExclusive: assert property (@(posedge CLK) disable iff (!RST)
		!(exMem.memRead && exMem.memWrite));

endmodule

/* hw/executeStage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module executeStage
(
	input  logic CLK,
	input  logic RST,
	idExBus.exec idEx,
	input  logic [1:0] fwdA,
	input  logic [1:0] fwdB,
	input  logic [`DATA_W-1:0] wbData,
	exMemBus.issue exMem,
	output logic redirect,
	output logic [`DATA_W-1:0] target
);

	logic [`DATA_W-1:0] aVal;
	logic [`DATA_W-1:0] bVal;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluOut;

	// operand source per forwarding select
	function automatic logic [`DATA_W-1:0] fwdMux(input logic [1:0] sel,
		input logic [`DATA_W-1:0] regVal, input logic [`DATA_W-1:0] exVal,
		input logic [`DATA_W-1:0] wbVal);
		logic [`DATA_W-1:0] val;
		case (sel)
			`FWD_EXMEM: val = exVal;
			`FWD_WB: val = wbVal;
			default: val = regVal;
		endcase
		return val;
	endfunction

	assign aVal = fwdMux(fwdA, idEx.operandA, exMem.aluResult, wbData);
	assign bVal = fwdMux(fwdB, idEx.operandB, exMem.aluResult, wbData);
	// immediate forms, address calc included
	assign opB = idEx.useImm ? idEx.imm : bVal;

	// ---------------------------------------------------------------------------
	// alu
	// ---------------------------------------------------------------------------
	always_comb
	begin
		if (idEx.aluFn == `ALU_PASS)
			aluOut = opB;
		else
		begin
			case (idEx.aluFn[`FN_W-1:0])
				`FN_AND: aluOut = aVal & opB;
				`FN_ADDU: aluOut = aVal + opB;
				`FN_OR: aluOut = aVal | opB;
				default: aluOut = aVal - opB;
			endcase
		end
	end

	// branch and jump resolve here, two younger slots get squashed upstream
	assign redirect = idEx.valid && (idEx.isJr || (idEx.isBeqz && aVal == '0));
	assign target = idEx.isJr ? aVal : idEx.imm;

	// EX/MEM flags
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
		end
		else
		begin
			exMem.regWrite <= idEx.regWrite;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
		end
	end

	// store data is the forwarded ry
	always_ff @(posedge CLK)
	begin
		exMem.aluResult <= aluOut;
		exMem.storeData <= bVal;
		exMem.dest <= idEx.dest;
	end

endmodule

/* hw/forwardUnit.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module forwardUnit
(
	idExBus.watch idEx,
	exMemBus.watch exMem,
	input  logic wbValid,
	input  logic [`REG_W-1:0] wbReg,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB
);

	// youngest producer wins
	// a load in EX/MEM never matches here, hazard unit stalls that case
	function automatic logic [1:0] pickSource(input logic [`REG_W-1:0] src);
		logic [1:0] sel;
		if (exMem.regWrite && !exMem.memRead && exMem.dest == src)
			sel = `FWD_EXMEM;
		else if (wbValid && wbReg == src)
			sel = `FWD_WB;
		else
			sel = `FWD_REG;
		return sel;
	endfunction

	always_comb
	begin
		fwdA = pickSource(idEx.srcA);
		fwdB = pickSource(idEx.srcB);
	end

endmodule

/* hw/hazardUnit.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module hazardUnit
	import cpuPkg::*;
(
	input  logic [`DATA_W-1:0] ifInstr,
	idExBus.watch idEx,
	output logic stall
);

	instrWord iw;
	logic readsRx;
	logic readsRy;

	assign iw = ifInstr;

	// which source fields the IF/ID word really reads
	always_comb
	begin
		readsRx = 1'b0;
		readsRy = 1'b0;
		case (iw.regView.op)
			`OP_ADDIU, `OP_LW, `OP_BEQZ, `OP_JR:
				readsRx = 1'b1;
			`OP_RRR, `OP_SW:
			begin
				readsRx = 1'b1;
				readsRy = 1'b1;
			end
			default:
			begin
				readsRx = 1'b0;
				readsRy = 1'b0;
			end
		endcase
	end

	// load in execute feeding the next instruction
	assign stall = idEx.valid && idEx.memRead &&
		((readsRx && idEx.dest == iw.regView.rx) || (readsRy && idEx.dest == iw.regView.ry));

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module decodeStage
	import cpuPkg::*;
(
	input  logic CLK,
	input  logic RST,
	input  logic [`DATA_W-1:0] ifInstr,
	input  logic [`DATA_W-1:0] ifPcPlus,
	input  logic stall,
	input  logic redirect,
	input  logic wbValid,
	input  logic [`REG_W-1:0] wbReg,
	input  logic [`DATA_W-1:0] wbData,
	idExBus.issue idEx
);

	instrWord iw;
	logic [`DATA_W-1:0] regs [`NUM_REGS];
	// decoded, not yet registered
	logic dValid;
	logic dRegWrite;
	logic dMemRead;
	logic dMemWrite;
	logic dIsBeqz;
	logic dIsJr;
	logic dUseImm;
	logic [`ALU_W-1:0] dAluFn;
	logic [`DATA_W-1:0] dImm;
	logic [`REG_W-1:0] dDest;
	logic [`DATA_W-1:0] immS8;
	logic [`DATA_W-1:0] immZ8;
	logic [`DATA_W-1:0] immS5;
	logic [`DATA_W-1:0] rdA;
	logic [`DATA_W-1:0] rdB;
	logic bubble;

	assign iw = ifInstr;
	assign immS8 = {{(`DATA_W-8){iw.immView.imm8[7]}}, iw.immView.imm8};
	assign immZ8 = {{(`DATA_W-8){1'b0}}, iw.immView.imm8};
	assign immS5 = {{(`DATA_W-5){iw.memView.imm5[4]}}, iw.memView.imm5};
	assign bubble = stall || redirect;

	// ---------------------------------------------------------------------------
	// opcode decode
	// ---------------------------------------------------------------------------
	always_comb
	begin
		dValid = 1'b1;
		dRegWrite = 1'b0;
		dMemRead = 1'b0;
		dMemWrite = 1'b0;
		dIsBeqz = 1'b0;
		dIsJr = 1'b0;
		dUseImm = 1'b0;
		dAluFn = {1'b0, `FN_ADDU};
		dImm = immS8;
		// most forms write back to rx
		dDest = iw.regView.rx;
		case (iw.regView.op)
			`OP_ADDIU:
			begin
				dRegWrite = 1'b1;
				dUseImm = 1'b1;
			end
			`OP_LI:
			begin
				dRegWrite = 1'b1;
				dUseImm = 1'b1;
				dAluFn = `ALU_PASS;
				dImm = immZ8;
			end
			`OP_RRR:
			begin
				dRegWrite = 1'b1;
				dAluFn = {1'b0, iw.regView.fn};
				dDest = iw.regView.rz;
			end
			`OP_LW:
			begin
				dRegWrite = 1'b1;
				dMemRead = 1'b1;
				dUseImm = 1'b1;
				dImm = immS5;
				dDest = iw.memView.ry;
			end
			`OP_SW:
			begin
				dMemWrite = 1'b1;
				dUseImm = 1'b1;
				dImm = immS5;
			end
			`OP_BEQZ:
			begin
				dIsBeqz = 1'b1;
				// target resolved here so execute only tests rx
				dImm = ifPcPlus + immS8;
			end
			`OP_JR:
				dIsJr = 1'b1;
			`OP_NOP:
				dValid = 1'b0;
			default:
				dValid = 1'b0;
		endcase
	end

	// register file with write-through on a same-cycle write-back
	assign rdA = (wbValid && wbReg == iw.regView.rx) ? wbData : regs[iw.regView.rx];
	assign rdB = (wbValid && wbReg == iw.regView.ry) ? wbData : regs[iw.regView.ry];

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wbValid)
		begin
			regs[wbReg] <= wbData;
		end
	end

	// ---------------------------------------------------------------------------
	// ID/EX register
	// ---------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.memRead <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.isBeqz <= 1'b0;
			idEx.isJr <= 1'b0;
		end
		// stall or squash loads a bubble
		else if (bubble)
		begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.memRead <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.isBeqz <= 1'b0;
			idEx.isJr <= 1'b0;
		end
		else
		begin
			idEx.valid <= dValid;
			idEx.regWrite <= dRegWrite;
			idEx.memRead <= dMemRead;
			idEx.memWrite <= dMemWrite;
			idEx.isBeqz <= dIsBeqz;
			idEx.isJr <= dIsJr;
		end
	end

	// operands and ids carry no meaning in a bubble
	always_ff @(posedge CLK)
	begin
		idEx.aluFn <= dAluFn;
		idEx.useImm <= dUseImm;
		idEx.operandA <= rdA;
		idEx.operandB <= rdB;
		idEx.imm <= dImm;
		idEx.srcA <= iw.regView.rx;
		idEx.srcB <= iw.regView.ry;
		idEx.dest <= dDest;
	end

	// the stall bubble pushes the load out of ID/EX, so stall cannot repeat
	stallOnce: assert property (@(posedge CLK) disable iff (!RST) stall |=> !stall);

endmodule

/* hw/fetchStage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module fetchStage
(
	input  logic CLK,
	input  logic RST,
	input  logic stall,
	input  logic redirect,
	input  logic [`DATA_W-1:0] target,
	output logic [`DATA_W-1:0] imemAddr,
	input  logic [`DATA_W-1:0] imemData,
	output logic [`DATA_W-1:0] ifInstr,
	output logic [`DATA_W-1:0] ifPcPlus
);

	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] pcPlus;

	// instruction memory is read straight from the pc
	assign imemAddr = pc;
	assign pcPlus = pc + 1'b1;

	// pc and IF/ID word, redirect wins over stall
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			pc <= '0;
			ifInstr <= `NOP_WORD;
		end
		else if (redirect)
		begin
			pc <= target;
			// younger instruction in flight is dropped
			ifInstr <= `NOP_WORD;
		end
		else if (!stall)
		begin
			pc <= pcPlus;
			ifInstr <= imemData;
		end
	end

	// return address travels with the word, only beqz uses it
	always_ff @(posedge CLK)
	begin
		if (!stall)
			ifPcPlus <= pcPlus;
	end

	pcKnown: assert property (@(posedge CLK) disable iff (!RST) !$isunknown(imemAddr));

endmodule

/* hw/pipeBuses.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

// ---------------------------------------------------------------------------
// ID/EX register contents
// ---------------------------------------------------------------------------
interface idExBus;
	logic valid;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic isBeqz;
	logic isJr;
	logic [`ALU_W-1:0] aluFn;
	logic useImm;
	logic [`DATA_W-1:0] operandA;
	logic [`DATA_W-1:0] operandB;
	// immediate, or absolute branch target for beqz
	logic [`DATA_W-1:0] imm;
	logic [`REG_W-1:0] srcA;
	logic [`REG_W-1:0] srcB;
	logic [`REG_W-1:0] dest;

	modport issue (output valid, regWrite, memRead, memWrite, isBeqz, isJr, aluFn, useImm,
		operandA, operandB, imm, srcA, srcB, dest);
	modport exec (input valid, regWrite, memRead, memWrite, isBeqz, isJr, aluFn, useImm,
		operandA, operandB, imm, dest);
	// hazard and forwarding only look at ids and the load flag
	modport watch (input valid, memRead, srcA, srcB, dest);
endinterface

// ---------------------------------------------------------------------------
// EX/MEM register contents
// ---------------------------------------------------------------------------
interface exMemBus;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] storeData;
	logic [`REG_W-1:0] dest;

	modport issue (output regWrite, memRead, memWrite, aluResult, storeData, dest);
	modport mem (input regWrite, memRead, memWrite, aluResult, storeData, dest);
	modport watch (input regWrite, memRead, dest);
endinterface

/* hw/cpuPkg.sv */
`include "core_consts.svh"

package cpuPkg;

	// register form: op rx ry rz fn
	typedef struct packed
	{
		logic [`OP_W-1:0] op;
		logic [`REG_W-1:0] rx;
		logic [`REG_W-1:0] ry;
		logic [`REG_W-1:0] rz;
		logic [`FN_W-1:0] fn;
	} regFields;

	// immediate form: li, addiu, beqz
	typedef struct packed
	{
		logic [`OP_W-1:0] op;
		logic [`REG_W-1:0] rx;
		logic [7:0] imm8;
	} immFields;

	// memory form: lw, sw with short offset
	typedef struct packed
	{
		logic [`OP_W-1:0] op;
		logic [`REG_W-1:0] rx;
		logic [`REG_W-1:0] ry;
		logic [4:0] imm5;
	} memFields;

	// one fetched word, three ways of reading it
	typedef union packed
	{
		regFields regView;
		immFields immView;
		memFields memView;
	} instrWord;

endpackage

/* hw/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and register file sizes
`define DATA_W 16
`define REG_W 3
`define NUM_REGS 8
`define OP_W 5
`define FN_W 2

// data memory, word addressed by the low address bits
`define DMEM_WORDS 256
`define DMEM_AW 8

// major opcodes, anything else decodes as nop
`define OP_ADDIU 5'b01001
`define OP_LI 5'b01101
`define OP_RRR 5'b11100
`define OP_LW 5'b10011
`define OP_SW 5'b11011
`define OP_BEQZ 5'b00100
`define OP_JR 5'b11110
`define OP_NOP 5'b00001

// function field of the register form
`define FN_AND 2'b00
`define FN_ADDU 2'b01
`define FN_OR 2'b10
`define FN_SUBU 2'b11

// alu select: low bits are a function code, top bit passes operand b through
`define ALU_W 3
`define ALU_PASS 3'b100

// operand source selects for execute
`define FWD_REG 2'b00
`define FWD_EXMEM 2'b01
`define FWD_WB 2'b10

// nop opcode, all fields zero
`define NOP_WORD 16'h0800

`endif
